/* hdl/pdp8_pkg.sv */
`default_nettype none

package pdp8_pkg;

    localparam int WORD_W    = 12;    // Data word width
    localparam int ADDR_W    = 12;    // Address width
    localparam int MEM_WORDS = 4096;  // 4K core

    // Page zero locations that count up on an indirect reference
    localparam logic [ADDR_W-1:0] AUTO_LO = 12'o0010;
    localparam logic [ADDR_W-1:0] AUTO_HI = 12'o0017;

    // Major states of the processor
    typedef enum logic [4:0] {
        HALT = 5'd0,   // Stopped, front panel owns the machine
        F0   = 5'd1,   // Instruction fetch
        F1   = 5'd2,   // Decode, operate execution
        D0   = 5'd3,   // Pointer read
        D1   = 5'd4,   // Auto-index write-back
        E0   = 5'd5,   // Operand cycle
        E1   = 5'd6,   // ISZ write-back
        DB0  = 5'd7,   // Data break entry
        DB1  = 5'd8,   // Wait for channel write
        DB2  = 5'd9    // Data break exit
    } major_state_t;

    // Opcodes in IR[11:9]
    typedef enum logic [2:0] {
        OP_AND = 3'o0,
        OP_TAD = 3'o1,
        OP_ISZ = 3'o2,
        OP_DCA = 3'o3,
        OP_JMS = 3'o4,
        OP_JMP = 3'o5,
        OP_IOT = 3'o6,  // Executes as a no-op
        OP_OPR = 3'o7
    } opcode_t;

endpackage

`default_nettype wire

/* hdl/wb_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if;
    import pdp8_pkg::*;

    logic              cyc;    // Bus cycle in progress
    logic              stb;    // Transfer strobe
    logic              we;     // Write enable
    logic [ADDR_W-1:0] adr;
    logic [WORD_W-1:0] dat_w;
    logic [WORD_W-1:0] dat_r;
    logic              ack;    // One-cycle acknowledge

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

/* hdl/major_state.sv */
`timescale 1ns/1ps
`default_nettype none

module major_state (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            run,
    input  wire                            ack,
    input  wire [pdp8_pkg::WORD_W-1:0]     instruction,
    input  wire                            auto_index,
    input  wire                            break_pending,
    input  wire                            halt_op,
    output pdp8_pkg::major_state_t         state
);
    import pdp8_pkg::*;

    opcode_t      op;
    logic         indirect;
    logic         mri;           // Memory reference instruction
    logic         finish;        // Instruction boundary this cycle
    major_state_t next_state;
    major_state_t resume_state;  // Where DB2 returns to

    assign op       = opcode_t'(instruction[11:9]);
    assign indirect = instruction[8];
    assign mri      = (op != OP_IOT) && (op != OP_OPR);

    always_comb begin
        next_state = state;
        finish     = 1'b0;
        case (state)
            HALT: if (run) next_state = F0;
            F0: if (ack) next_state = F1;
            F1: begin
                if (mri && indirect) next_state = D0;
                else if (mri && op != OP_JMP) next_state = E0;
                else finish = 1'b1;   // Direct JMP, OPR, IOT
            end
            D0: begin
                if (ack) begin
                    if (auto_index) next_state = D1;
                    else if (op == OP_JMP) finish = 1'b1;
                    else next_state = E0;
                end
            end
            D1: begin
                if (ack) begin
                    if (op == OP_JMP) finish = 1'b1;
                    else next_state = E0;
                end
            end
            E0: begin
                if (ack) begin
                    if (op == OP_ISZ) next_state = E1;
                    else finish = 1'b1;
                end
            end
            E1: if (ack) finish = 1'b1;
            DB0: next_state = DB1;
            DB1: if (!break_pending) next_state = DB2;  // Channel write done
            DB2: next_state = resume_state;
            default: next_state = HALT;
        endcase

        // End of instruction: halt beats a break, a break beats the next fetch
        if (finish) begin
            if (halt_op) next_state = HALT;
            else if (break_pending) next_state = DB0;
            else next_state = F0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= HALT;
            resume_state <= F0;
        end else begin
            state <= next_state;
            if (finish) resume_state <= halt_op ? HALT : F0;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {HALT, F0, F1, D0, D1, E0, E1, DB0, DB1, DB2})
        else $error("major state out of range");

endmodule

`default_nettype wire

/* hdl/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            run,
    input  wire [pdp8_pkg::ADDR_W-1:0]     start_addr,
    input  wire                            break_pending,
    wb_bus_if.master                       cpu_bus,
    output logic [pdp8_pkg::WORD_W-1:0]    ac,
    output logic [pdp8_pkg::WORD_W-1:0]    pc,
    output logic                           link,
    output logic                           halted
);
    import pdp8_pkg::*;

    major_state_t      state;
    opcode_t           op;
    logic [WORD_W-1:0] ir;
    logic [ADDR_W-1:0] ma;          // Memory address
    logic [WORD_W-1:0] md;          // Pointer plus one or ISZ count
    logic              ack_gap;     // Idle cycle after each ack
    logic              auto_index;
    logic              halt_op;
    logic              bus_state;
    logic [ADDR_W-1:0] ea;          // Effective address
    logic [WORD_W:0]   tad_sum;     // Carry in top bit
    logic [WORD_W-1:0] opr_ac;
    logic              opr_link;
    logic              opr_skip;

    major_state u_seq (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .ack           (cpu_bus.ack),
        .instruction   (ir),
        .auto_index    (auto_index),
        .break_pending (break_pending),
        .halt_op       (halt_op),
        .state         (state)
    );

    assign op         = opcode_t'(ir[11:9]);
    assign ea         = {ir[7] ? ma[11:7] : 5'b0, ir[6:0]};  // Current page or page zero
    assign auto_index = (ma >= AUTO_LO) && (ma <= AUTO_HI);
    assign halt_op    = (op == OP_OPR) && ir[8] && !ir[0] && ir[1];
    assign halted     = (state == HALT);
    assign tad_sum    = {1'b0, ac} + {1'b0, cpu_bus.dat_r};

    assign bus_state     = state inside {F0, D0, D1, E0, E1};
    assign cpu_bus.cyc   = bus_state && !ack_gap;
    assign cpu_bus.stb   = bus_state && !ack_gap;
    assign cpu_bus.adr   = (state == F0) ? pc : ma;
    assign cpu_bus.we    = (state == D1) || (state == E1) ||
                           (state == E0 && (op == OP_DCA || op == OP_JMS));
    assign cpu_bus.dat_w = (state == D1 || state == E1) ? md :
                           (op == OP_DCA) ? ac : pc;   // JMS stores return address

    // Operate microinstructions in PDP-8 event order
    always_comb begin
        logic [WORD_W-1:0] acc;
        logic              lnk;
        logic              cond;
        acc      = ac;
        lnk      = link;
        cond     = 1'b0;
        opr_skip = 1'b0;
        if (!ir[8]) begin
            if (ir[7]) acc = '0;                   // CLA
            if (ir[6]) lnk = 1'b0;                 // CLL
            if (ir[5]) acc = ~acc;                 // CMA
            if (ir[4]) lnk = ~lnk;                 // CML
            if (ir[0]) {lnk, acc} = {lnk, acc} + 1'b1;  // IAC, carry flips L
        end else if (!ir[0]) begin
            cond = (ir[6] && acc[11]) || (ir[5] && acc == '0) || (ir[4] && lnk);
            opr_skip = cond ^ ir[3];               // Reverse sense
            if (ir[7]) acc = '0;
        end
        opr_ac   = acc;
        opr_link = lnk;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            ac      <= '0;
            link    <= 1'b0;
            ir      <= '0;
            ack_gap <= 1'b0;
        end else begin
            ack_gap <= cpu_bus.ack;
            case (state)
                HALT: if (run) pc <= start_addr;
                F0: if (cpu_bus.ack) begin
                    ir <= cpu_bus.dat_r;
                    ma <= pc;                      // Keeps the instruction page
                    pc <= pc + 1'b1;
                end
                F1: begin
                    ma <= ea;
                    if (op == OP_JMP && !ir[8]) pc <= ea;
                    if (op == OP_OPR) begin
                        ac   <= opr_ac;
                        link <= opr_link;
                        if (opr_skip) pc <= pc + 1'b1;
                    end
                end
                D0: if (cpu_bus.ack) begin
                    if (auto_index) md <= cpu_bus.dat_r + 1'b1;
                    else ma <= cpu_bus.dat_r;
                    if (!auto_index && op == OP_JMP) pc <= cpu_bus.dat_r;
                end
                D1: if (cpu_bus.ack) begin
                    ma <= md;                      // Incremented pointer
                    if (op == OP_JMP) pc <= md;
                end
                E0: if (cpu_bus.ack) begin
                    case (op)
                        OP_AND: ac <= ac & cpu_bus.dat_r;
                        OP_TAD: begin
                            ac   <= tad_sum[WORD_W-1:0];
                            link <= link ^ tad_sum[WORD_W];
                        end
                        OP_ISZ: md <= cpu_bus.dat_r + 1'b1;
                        OP_DCA: ac <= '0;
                        OP_JMS: pc <= ma + 1'b1;
                        default: ;
                    endcase
                end
                E1: if (cpu_bus.ack && md == '0) pc <= pc + 1'b1;  // ISZ skip
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/data_break.sv */
`timescale 1ns/1ps
`default_nettype none

module data_break (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            dev_valid,
    input  wire [pdp8_pkg::ADDR_W-1:0]     dev_addr,
    input  wire [pdp8_pkg::WORD_W-1:0]     dev_data,
    output logic                           dev_ready,
    output logic                           break_pending,
    wb_bus_if.master                       dma_bus
);
    import pdp8_pkg::*;

    logic              full;       // Buffer holds a word
    logic              accept;
    logic [ADDR_W-1:0] buf_addr;
    logic [WORD_W-1:0] buf_data;

    assign dev_ready     = !full;
    assign accept        = dev_valid && !full;
    assign break_pending = full;

    assign dma_bus.cyc   = full;
    assign dma_bus.stb   = full;
    assign dma_bus.we    = 1'b1;      // Device to memory only
    assign dma_bus.adr   = buf_addr;
    assign dma_bus.dat_w = buf_data;

    always_ff @(posedge clk) begin
        if (reset) full <= 1'b0;
        else if (accept) full <= 1'b1;
        else if (dma_bus.ack) full <= 1'b0;  // Released on write ack
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr <= dev_addr;
            buf_data <= dev_data;
        end
    end

    // A write request only follows a captured word
    a_stb_after_word: assert property (@(posedge clk) disable iff (reset)
        $rose(dma_bus.stb) |-> $past(accept))
        else $error("channel strobe without a buffered word");

    a_drop_after_ack: assert property (@(posedge clk) disable iff (reset)
        dma_bus.ack |=> !dma_bus.stb)
        else $error("channel strobe held after ack");

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire         clk,
    input  wire         reset,
    wb_bus_if.slave     cpu_bus,
    wb_bus_if.slave     dma_bus,
    wb_bus_if.master    mem_bus
);

    logic busy;        // Bus cycle was open last cycle
    logic owner_dma;   // Holder of the grant
    logic owner_cyc;
    logic sel_dma;

    assign owner_cyc = owner_dma ? dma_bus.cyc : cpu_bus.cyc;
    // Fresh arbitration once the holder drops cyc, DMA first
    assign sel_dma   = (busy && owner_cyc) ? owner_dma : dma_bus.cyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            owner_dma <= 1'b0;
        end else begin
            busy      <= mem_bus.cyc;
            owner_dma <= sel_dma;
        end
    end

    assign mem_bus.cyc   = sel_dma ? dma_bus.cyc   : cpu_bus.cyc;
    assign mem_bus.stb   = sel_dma ? dma_bus.stb   : cpu_bus.stb;
    assign mem_bus.we    = sel_dma ? dma_bus.we    : cpu_bus.we;
    assign mem_bus.adr   = sel_dma ? dma_bus.adr   : cpu_bus.adr;
    assign mem_bus.dat_w = sel_dma ? dma_bus.dat_w : cpu_bus.dat_w;

    assign cpu_bus.ack   = mem_bus.ack && !sel_dma;   // Loser just waits
    assign dma_bus.ack   = mem_bus.ack && sel_dma;
    assign cpu_bus.dat_r = mem_bus.dat_r;
    assign dma_bus.dat_r = mem_bus.dat_r;

    a_one_ack: assert property (@(posedge clk) disable iff (reset)
        !(cpu_bus.ack && dma_bus.ack))
        else $error("both masters acked");

    // Grant hold keeps a pending request steady at memory
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_bus.stb && !mem_bus.ack |=> mem_bus.stb && $stable(mem_bus.adr))
        else $error("request changed before ack");

endmodule

`default_nettype wire

/* hdl/core_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module core_memory (
    input  wire         clk,
    input  wire         reset,
    wb_bus_if.slave     mem_bus
);
    import pdp8_pkg::*;

    logic [WORD_W-1:0] mem [MEM_WORDS];
    logic [WORD_W-1:0] rd_data;
    logic              waited;   // Wait state spent
    logic              ack;
    logic              hit;      // Transfer completes this edge

    assign hit = mem_bus.cyc && mem_bus.stb && waited && !ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            waited <= 1'b0;
            ack    <= 1'b0;
        end else begin
            ack    <= hit;
            waited <= mem_bus.cyc && mem_bus.stb && !ack && !waited;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (mem_bus.we) mem[mem_bus.adr] <= mem_bus.dat_w;
            rd_data <= mem[mem_bus.adr];
        end
    end

    assign mem_bus.ack   = ack;
    assign mem_bus.dat_r = rd_data;   // Valid with ack

    a_ack_in_stb: assert property (@(posedge clk) disable iff (reset)
        mem_bus.ack |-> mem_bus.stb)
        else $error("memory ack without strobe");

endmodule

`default_nettype wire

/* hdl/pdp8_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pdp8_top (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            run,
    input  wire [pdp8_pkg::ADDR_W-1:0]     start_addr,
    input  wire                            dev_valid,
    output logic                           dev_ready,
    input  wire [pdp8_pkg::ADDR_W-1:0]     dev_addr,
    input  wire [pdp8_pkg::WORD_W-1:0]     dev_data,
    output logic                           halted,
    output logic [pdp8_pkg::WORD_W-1:0]    ac,
    output logic                           link,
    output logic [pdp8_pkg::WORD_W-1:0]    pc
);

    logic break_pending;   // Channel to sequencer

    wb_bus_if cpu_bus ();
    wb_bus_if dma_bus ();
    wb_bus_if mem_bus ();

    cpu_core u_cpu (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .start_addr    (start_addr),
        .break_pending (break_pending),
        .cpu_bus       (cpu_bus),
        .ac            (ac),
        .pc            (pc),
        .link          (link),
        .halted        (halted)
    );

    data_break u_dma (
        .clk           (clk),
        .reset         (reset),
        .dev_valid     (dev_valid),
        .dev_addr      (dev_addr),
        .dev_data      (dev_data),
        .dev_ready     (dev_ready),
        .break_pending (break_pending),
        .dma_bus       (dma_bus)
    );

    bus_arbiter u_arb (
        .clk     (clk),
        .reset   (reset),
        .cpu_bus (cpu_bus),
        .dma_bus (dma_bus),
        .mem_bus (mem_bus)
    );

    core_memory u_mem (
        .clk     (clk),
        .reset   (reset),
        .mem_bus (mem_bus)
    );

endmodule

`default_nettype wire

/* sim/tb_cases.svh */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

    localparam int NUM_CASES = 8;
    localparam int MAX_WORDS = 12;

    logic [11:0] prog_addr  [NUM_CASES][MAX_WORDS];
    logic [11:0] prog_word  [NUM_CASES][MAX_WORDS];
    int          prog_len   [NUM_CASES];   // Filled pairs per row
    logic [11:0] start_tab  [NUM_CASES];
    bit          late_en    [NUM_CASES];   // Deposit while running
    logic [11:0] late_addr  [NUM_CASES];
    logic [11:0] late_val   [NUM_CASES];
    int          late_delay [NUM_CASES];   // Cycles after run
    logic [11:0] exp_ac     [NUM_CASES];
    logic        exp_link   [NUM_CASES];
    logic [11:0] exp_pc     [NUM_CASES];

    task automatic put_word(input int c, input logic [11:0] addr, input logic [11:0] word);
        prog_addr[c][prog_len[c]] = addr;
        prog_word[c][prog_len[c]] = word;
        prog_len[c] = prog_len[c] + 1;
    endtask

    // Four words at consecutive addresses
    task automatic put_code(input int c, input logic [11:0] base,
                            input logic [11:0] w0, w1, w2, w3);
        put_word(c, base, w0);
        put_word(c, base + 12'd1, w1);
        put_word(c, base + 12'd2, w2);
        put_word(c, base + 12'd3, w3);
    endtask

    task automatic set_expect(input int c, input logic [11:0] start, input logic [11:0] e_ac,
                              input logic e_link, input logic [11:0] e_pc);
        start_tab[c] = start;
        exp_ac[c]    = e_ac;
        exp_link[c]  = e_link;
        exp_pc[c]    = e_pc;
    endtask

    task automatic build_cases();
        int          r;
        logic [11:0] a;
        logic [11:0] b;
        logic [12:0] sum;   // Carry out lands in L
        logic [11:0] v;
        r   = $random(seed);
        a   = r[11:0];
        r   = $random(seed);
        b   = r[11:0];
        sum = {1'b0, a} + {1'b0, b};
        r   = $random(seed);
        v   = (r[11:0] == 12'o0) ? 12'o0001 : r[11:0];

        put_code(0, 12'o0200, 12'o7300, 12'o1250, 12'o1251, 12'o7402);  // TAD A, TAD B
        put_word(0, 12'o0250, a);
        put_word(0, 12'o0251, b);
        set_expect(0, 12'o0200, sum[11:0], sum[12], 12'o0204);

        put_code(1, 12'o0200, 12'o7300, 12'o1250, 12'o3252, 12'o1252);  // DCA then TAD back
        put_word(1, 12'o0204, 12'o0251);                                  // AND B
        put_word(1, 12'o0205, 12'o7402);
        put_word(1, 12'o0250, a);
        put_word(1, 12'o0251, b);
        set_expect(1, 12'o0200, a & b, 1'b0, 12'o0206);

        put_code(2, 12'o0200, 12'o7300, 12'o1410, 12'o1410, 12'o7402);  // Two TAD I 0010
        put_word(2, 12'o0010, 12'o0277);
        put_word(2, 12'o0277, 12'o7000);   // Pointer itself, never the operand
        put_word(2, 12'o0300, 12'o0111);
        put_word(2, 12'o0301, 12'o0222);
        set_expect(2, 12'o0200, 12'o0333, 1'b0, 12'o0204);

        put_code(3, 12'o0200, 12'o7300, 12'o7001, 12'o2250, 12'o5201);  // IAC, ISZ loop
        put_word(3, 12'o0204, 12'o7402);
        put_word(3, 12'o0250, 12'o7775);   // Minus three
        set_expect(3, 12'o0200, 12'o0003, 1'b0, 12'o0205);

        put_code(4, 12'o0200, 12'o7300, 12'o4250, 12'o7402, 12'o7402);  // JMS 0250
        put_code(4, 12'o0250, 12'o0000, 12'o1260, 12'o5650, 12'o7402);  // Return by JMP I
        put_word(4, 12'o0260, 12'o0555);
        set_expect(4, 12'o0200, 12'o0555, 1'b0, 12'o0203);

        // CLA CMA IAC carries into L, then CLL CML and CMA
        put_code(5, 12'o0200, 12'o7300, 12'o7241, 12'o7120, 12'o7040);
        put_word(5, 12'o0204, 12'o7402);
        set_expect(5, 12'o0200, 12'o7777, 1'b1, 12'o0205);

        // SNA CLA, SZL and SZA skip over a HLT each, SNL falls through
        put_code(6, 12'o0200, 12'o7300, 12'o7001, 12'o7650, 12'o7402);
        put_code(6, 12'o0204, 12'o7430, 12'o7402, 12'o7440, 12'o7402);
        put_word(6, 12'o0210, 12'o7420);
        put_word(6, 12'o0211, 12'o7402);
        set_expect(6, 12'o0200, 12'o0000, 1'b0, 12'o0212);

        put_code(7, 12'o0200, 12'o7300, 12'o1100, 12'o7450, 12'o5201);  // Poll 0100
        put_word(7, 12'o0204, 12'o7402);
        put_word(7, 12'o0100, 12'o0000);
        late_en[7]    = 1'b1;
        late_addr[7]  = 12'o0100;
        late_val[7]   = v;
        late_delay[7] = 60;
        set_expect(7, 12'o0200, v, 1'b0, 12'o0205);
    endtask

`endif

/* sim/tb_pdp8.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pdp8;

    localparam int RESET_CYCLES = 10;

    logic        clk;
    logic        reset;
    logic        run;
    logic [11:0] start_addr;
    logic        dev_valid;
    logic        dev_ready;
    logic [11:0] dev_addr;
    logic [11:0] dev_data;
    logic        halted;
    logic [11:0] ac;
    logic        link;
    logic [11:0] pc;
    int          seed = 32'h37f9;
    int          cycle_count = 0;

    `include "tb_cases.svh"

    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 400 * NUM_CASES;

    pdp8_top DUT (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .start_addr (start_addr),
        .dev_valid  (dev_valid),
        .dev_ready  (dev_ready),
        .dev_addr   (dev_addr),
        .dev_data   (dev_data),
        .halted     (halted),
        .ac         (ac),
        .link       (link),
        .pc         (pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("** FAIL **");
            $fatal(1, "simulation timed out after %0d cycles", cycle_count);
        end
    end

    task automatic check_value(input string name, input logic [11:0] expected,
                               input logic [11:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // One word through the device port, accepted on the second edge
    task automatic deposit_word(input logic [11:0] addr, input logic [11:0] word);
        @(negedge clk);
        while (!dev_ready) @(negedge clk);
        @(posedge clk);
        dev_valid <= 1'b1;
        dev_addr  <= addr;
        dev_data  <= word;
        @(posedge clk);
        dev_valid <= 1'b0;
    endtask

    task automatic load_program(input int c);
        int i;
        for (i = 0; i < prog_len[c]; i++) begin
            deposit_word(prog_addr[c][i], prog_word[c][i]);
        end
        @(negedge clk);
        while (!dev_ready) @(negedge clk);  // Last word in memory
    endtask

    task automatic run_program(input int c);
        int n;
        n = 0;
        @(posedge clk);
        run        <= 1'b1;
        start_addr <= start_tab[c];
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        assert (!halted) else begin
            $display("processor stayed halted after the run pulse");
            $display("** FAIL **");
            $fatal(1, "run pulse ignored");
        end
        while (!halted) begin
            if (late_en[c] && n == late_delay[c]) begin
                deposit_word(late_addr[c], late_val[c]);  // Break while running
            end
            @(negedge clk);
            n++;
        end
    endtask

    initial begin
        int c;
        reset      = 1'b1;
        run        = 1'b0;
        start_addr = '0;
        dev_valid  = 1'b0;
        dev_addr   = '0;
        dev_data   = '0;
        build_cases();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("halted", 12'd1, {11'b0, halted});
        check_value("ac", 12'd0, ac);
        check_value("link", 12'd0, {11'b0, link});
        check_value("pc", 12'd0, pc);
        check_value("dev_ready", 12'd1, {11'b0, dev_ready});

        for (c = 0; c < NUM_CASES; c++) begin
            load_program(c);
            run_program(c);
            check_value("ac", exp_ac[c], ac);
            check_value("link", {11'b0, exp_link[c]}, {11'b0, link});
            check_value("pc", exp_pc[c], pc);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+sim
hdl/pdp8_pkg.sv
hdl/wb_bus_if.sv
hdl/major_state.sv
hdl/cpu_core.sv
hdl/data_break.sv
hdl/bus_arbiter.sv
hdl/core_memory.sv
hdl/pdp8_top.sv
sim/tb_pdp8.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the PDP-8 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module tb_pdp8 \
    --Mdir obj_dir -o tb_pdp8

./obj_dir/tb_pdp8
